// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath and pc width
`define XLEN 32

// register file has 32 entries
`define REG_ADDR_W 5

// rv32i base instruction fields
`define OPCODE_W 7
`define FUNC3_W 3
`define FUNC7_W 7

`endif

// ==== logic/riscv_decode_pkg.sv ====
`include "decode_params.svh"

package riscv_decode_pkg;

    // rv32i major opcodes handled by this stage
    typedef enum logic [`OPCODE_W-1:0] {
        OP_ALU_I  = 7'b0010011,
        OP_ALU    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LW     = 7'b0000011,
        OP_SW     = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [`FUNC3_W-1:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } func3_alu_e;

    // 3'b010 and 3'b011 are unused
    typedef enum logic [`FUNC3_W-1:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } func3_branch_e;

    typedef enum logic [`FUNC7_W-1:0] {
        F7_ALU_NORMAL   = 7'b0000000,
        F7_ALU_MODIFIED = 7'b0100000
    } func7_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic {
        RS1,
        PC
    } op_a_sel_e;

    typedef enum logic {
        RS2,
        IMM
    } op_b_sel_e;

    // PC_4 is the link value for jal
    typedef enum logic [1:0] {
        ALU,
        MEM,
        PC_4
    } wb_origin_e;

    typedef enum logic [2:0] {
        BNONE, JUMP, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } jump_kind_e;

    // r-type view, other formats share these bit positions
    typedef struct packed {
        logic [`FUNC7_W-1:0]    func7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNC3_W-1:0]    func3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } instr_t;

endpackage

// ==== logic/decoded_if.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

interface decoded_if
    import riscv_decode_pkg::*;
();

    logic                   write_enable;
    op_a_sel_e              rs1_or_pc;
    op_b_sel_e              rs2_or_imm;
    alu_op_e                alu_op;
    wb_origin_e             wb_origin;
    logic                   store_to_mem;
    jump_kind_e             jump_kind;
    logic [`REG_ADDR_W-1:0] addr_rs1;
    logic [`REG_ADDR_W-1:0] addr_rs2;
    logic [`REG_ADDR_W-1:0] addr_rd;

    modport producer (
        output write_enable, rs1_or_pc, rs2_or_imm, alu_op, wb_origin,
        output store_to_mem, jump_kind, addr_rs1, addr_rs2, addr_rd
    );

    modport consumer (
        input write_enable, rs1_or_pc, rs2_or_imm, alu_op, wb_origin,
        input store_to_mem, jump_kind, addr_rs1, addr_rs2, addr_rd
    );

endinterface

// ==== logic/alu_op_decoder.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module alu_op_decoder
    import riscv_decode_pkg::*;
(
    input  func3_alu_e func3_i,
    input  func7_e     func7_i,
    input  logic       is_imm_i,
    output alu_op_e    alu_op_o,
    output logic       alu_legal_o
);

    logic f7_normal;
    logic f7_modified;
    logic f7_ok;

    assign f7_normal   = (func7_i == F7_ALU_NORMAL);
    assign f7_modified = (func7_i == F7_ALU_MODIFIED);

    // immediate form ignores func7 outside the shifts
    assign f7_ok = is_imm_i | f7_normal;

    always_comb begin
        alu_op_o    = ADD;
        alu_legal_o = 1'b1;

        case (func3_i)
            F3_ADD_SUB: begin
                if (f7_ok) begin
                    alu_op_o = ADD;
                end else if (f7_modified) begin
                    alu_op_o = SUB;
                end else begin
                    alu_legal_o = 1'b0;
                end
            end
            F3_SLL: begin
                alu_op_o    = SLL;
                alu_legal_o = f7_normal;
            end
            F3_SLT: begin
                alu_op_o    = SLT;
                alu_legal_o = f7_ok;
            end
            F3_SLTU: begin
                alu_op_o    = SLTU;
                alu_legal_o = f7_ok;
            end
            F3_XOR: begin
                alu_op_o    = XOR;
                alu_legal_o = f7_ok;
            end
            // srai keeps func7 checks, same as the register form
            F3_SRL_SRA: begin
                if (f7_normal) begin
                    alu_op_o = SRL;
                end else if (f7_modified) begin
                    alu_op_o = SRA;
                end else begin
                    alu_legal_o = 1'b0;
                end
            end
            F3_OR: begin
                alu_op_o    = OR;
                alu_legal_o = f7_ok;
            end
            F3_AND: begin
                alu_op_o    = AND;
                alu_legal_o = f7_ok;
            end
            default: begin
                alu_legal_o = 1'b0;
            end
        endcase

        if (!alu_legal_o) begin
            alu_op_o = ADD;
        end
    end

endmodule

// ==== logic/instr_classifier.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module instr_classifier
    import riscv_decode_pkg::*;
(
    input instr_t             instr_i,
    decoded_if.producer       dec
);

    opcode_e    opcode;
    alu_op_e    alu_op;
    logic       alu_legal;
    logic       is_imm;

    logic       legal;
    logic       use_rs1;
    logic       use_rs2;
    logic       write_enable;
    op_a_sel_e  rs1_or_pc;
    op_b_sel_e  rs2_or_imm;
    alu_op_e    op_sel;
    wb_origin_e wb_origin;
    logic       store_to_mem;
    jump_kind_e jump_kind;

    logic [`REG_ADDR_W-1:0] addr_rs1;
    logic [`REG_ADDR_W-1:0] addr_rs2;
    logic [`REG_ADDR_W-1:0] addr_rd;

    assign opcode = opcode_e'(instr_i.opcode);
    assign is_imm = (opcode == OP_ALU_I);

    alu_op_decoder u_alu_op_decoder (
        .func3_i     (func3_alu_e'(instr_i.func3)),
        .func7_i     (func7_e'(instr_i.func7)),
        .is_imm_i    (is_imm),
        .alu_op_o    (alu_op),
        .alu_legal_o (alu_legal)
    );

    always_comb begin
        // defaults are the nop fields
        legal        = 1'b1;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        write_enable = 1'b0;
        rs1_or_pc    = RS1;
        rs2_or_imm   = RS2;
        op_sel       = ADD;
        wb_origin    = ALU;
        store_to_mem = 1'b0;
        jump_kind    = BNONE;

        case (opcode)
            OP_ALU_I: begin
                write_enable = 1'b1;
                rs2_or_imm   = IMM;
                op_sel       = alu_op;
                legal        = alu_legal;
                use_rs1      = 1'b1;
            end
            OP_ALU: begin
                write_enable = 1'b1;
                op_sel       = alu_op;
                legal        = alu_legal;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
            end
            // lui adds the immediate to x0
            OP_LUI: begin
                write_enable = 1'b1;
                rs2_or_imm   = IMM;
            end
            OP_AUIPC: begin
                write_enable = 1'b1;
                rs1_or_pc    = PC;
                rs2_or_imm   = IMM;
            end
            OP_LW: begin
                write_enable = 1'b1;
                rs2_or_imm   = IMM;
                wb_origin    = MEM;
                use_rs1      = 1'b1;
            end
            OP_SW: begin
                rs2_or_imm   = IMM;
                store_to_mem = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
            end
            OP_BRANCH: begin
                rs1_or_pc    = PC;
                rs2_or_imm   = IMM;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                case (func3_branch_e'(instr_i.func3))
                    F3_BEQ:  jump_kind = BEQ;
                    F3_BNE:  jump_kind = BNE;
                    F3_BLT:  jump_kind = BLT;
                    F3_BGE:  jump_kind = BGE;
                    F3_BLTU: jump_kind = BLTU;
                    F3_BGEU: jump_kind = BGEU;
                    // never taken and no write, so behaves as a nop
                    default: jump_kind = BNONE;
                endcase
            end
            OP_JAL: begin
                write_enable = 1'b1;
                rs1_or_pc    = PC;
                rs2_or_imm   = IMM;
                wb_origin    = PC_4;
                jump_kind    = JUMP;
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // illegal encoding becomes x0 + x0 without write
        if (!legal) begin
            use_rs1      = 1'b0;
            use_rs2      = 1'b0;
            write_enable = 1'b0;
            rs1_or_pc    = RS1;
            rs2_or_imm   = RS2;
            op_sel       = ADD;
            wb_origin    = ALU;
            store_to_mem = 1'b0;
            jump_kind    = BNONE;
        end

        addr_rs1 = use_rs1 ? instr_i.rs1 : '0;
        addr_rs2 = use_rs2 ? instr_i.rs2 : '0;
        addr_rd  = write_enable ? instr_i.rd : '0;

        assert (!(store_to_mem && write_enable))
            else $error("store and register write decoded together");
    end

    assign dec.write_enable = write_enable;
    assign dec.rs1_or_pc    = rs1_or_pc;
    assign dec.rs2_or_imm   = rs2_or_imm;
    assign dec.alu_op       = op_sel;
    assign dec.wb_origin    = wb_origin;
    assign dec.store_to_mem = store_to_mem;
    assign dec.jump_kind    = jump_kind;
    assign dec.addr_rs1     = addr_rs1;
    assign dec.addr_rs2     = addr_rs2;
    assign dec.addr_rd      = addr_rd;

endmodule

// ==== logic/decode_output_reg.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_output_reg
    import riscv_decode_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  logic [`XLEN-1:0]       pc_i,
    input  instr_t                 instr_i,
    decoded_if.consumer            dec,

    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`XLEN-1:0]       pc_o,
    output instr_t                 instr_o,
    output logic                   write_enable_o,
    output op_a_sel_e              rs1_or_pc_o,
    output op_b_sel_e              rs2_or_imm_o,
    output alu_op_e                alu_op_o,
    output wb_origin_e             wb_origin_o,
    output logic                   store_to_mem_o,
    output jump_kind_e             jump_kind_o,
    output logic [`REG_ADDR_W-1:0] addr_rs1_o,
    output logic [`REG_ADDR_W-1:0] addr_rs2_o,
    output logic [`REG_ADDR_W-1:0] addr_rd_o
);

    logic accept;

    // free when empty or drained this cycle
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_o           <= pc_i;
            instr_o        <= instr_i;
            write_enable_o <= dec.write_enable;
            rs1_or_pc_o    <= dec.rs1_or_pc;
            rs2_or_imm_o   <= dec.rs2_or_imm;
            alu_op_o       <= dec.alu_op;
            wb_origin_o    <= dec.wb_origin;
            store_to_mem_o <= dec.store_to_mem;
            jump_kind_o    <= dec.jump_kind;
            addr_rs1_o     <= dec.addr_rs1;
            addr_rs2_o     <= dec.addr_rs2;
            addr_rd_o      <= dec.addr_rd;
        end
    end

    // stalled entry must not change or disappear
    property p_hold_while_stalled;
        @(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(pc_o) && $stable(instr_o) &&
            $stable({write_enable_o, rs1_or_pc_o, rs2_or_imm_o, alu_op_o, wb_origin_o}) &&
            $stable({store_to_mem_o, jump_kind_o, addr_rs1_o, addr_rs2_o, addr_rd_o});
    endproperty

    a_hold_while_stalled: assert property (p_hold_while_stalled)
        else $error("decoded outputs changed while stalled");

    a_empty_after_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("out_valid_o set right after reset");

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage
    import riscv_decode_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  logic [`XLEN-1:0]       pc_i,
    input  instr_t                 instr_i,

    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output logic [`XLEN-1:0]       pc_o,
    output instr_t                 instr_o,
    output logic                   write_enable_o,
    output op_a_sel_e              rs1_or_pc_o,
    output op_b_sel_e              rs2_or_imm_o,
    output alu_op_e                alu_op_o,
    output wb_origin_e             wb_origin_o,
    output logic                   store_to_mem_o,
    output jump_kind_e             jump_kind_o,
    output logic [`REG_ADDR_W-1:0] addr_rs1_o,
    output logic [`REG_ADDR_W-1:0] addr_rs2_o,
    output logic [`REG_ADDR_W-1:0] addr_rd_o
);

    // combinational decode fields
    decoded_if dec_if ();

    instr_classifier u_classifier (
        .instr_i (instr_i),
        .dec     (dec_if.producer)
    );

    // single pipeline register with handshake
    decode_output_reg u_output_reg (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .pc_i           (pc_i),
        .instr_i        (instr_i),
        .dec            (dec_if.consumer),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .pc_o           (pc_o),
        .instr_o        (instr_o),
        .write_enable_o (write_enable_o),
        .rs1_or_pc_o    (rs1_or_pc_o),
        .rs2_or_imm_o   (rs2_or_imm_o),
        .alu_op_o       (alu_op_o),
        .wb_origin_o    (wb_origin_o),
        .store_to_mem_o (store_to_mem_o),
        .jump_kind_o    (jump_kind_o),
        .addr_rs1_o     (addr_rs1_o),
        .addr_rs2_o     (addr_rs2_o),
        .addr_rd_o      (addr_rd_o)
    );

endmodule

// ==== verification/decode_ref_pkg.sv ====
`include "decode_params.svh"

package decode_ref_pkg;
    import riscv_decode_pkg::*;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       instr;
        logic                   write_enable;
        op_a_sel_e              a_sel;
        op_b_sel_e              b_sel;
        alu_op_e                alu_op;
        wb_origin_e             wb;
        logic                   store;
        jump_kind_e             jump;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } exp_t;

    function automatic alu_op_e op_from_func3(logic [2:0] f3);
        case (f3)
            3'd0: return ADD;
            3'd1: return SLL;
            3'd2: return SLT;
            3'd3: return SLTU;
            3'd4: return XOR;
            3'd5: return SRL;
            3'd6: return OR;
            default: return AND;
        endcase
    endfunction

    // expected fields per the rv32i subset rules
    function automatic exp_t ref_decode(logic [31:0] pc, logic [31:0] instr);
        exp_t       e;
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       legal;
        logic       use1;
        logic       use2;
        op = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        e = '{pc: pc, instr: instr, write_enable: 1'b0, a_sel: RS1, b_sel: RS2, alu_op: ADD,
              wb: ALU, store: 1'b0, jump: BNONE, rs1: '0, rs2: '0, rd: '0};
        legal = 1'b1;
        use1 = 1'b0;
        use2 = 1'b0;
        case (op)
            7'b0010011: begin
                e.write_enable = 1'b1;
                e.b_sel = IMM;
                use1 = 1'b1;
                if (f3 == 3'd1) legal = (f7 == 7'h00);
                if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
                e.alu_op = (f3 == 3'd5 && f7 == 7'h20) ? SRA : op_from_func3(f3);
            end
            7'b0110011: begin
                e.write_enable = 1'b1;
                use1 = 1'b1;
                use2 = 1'b1;
                if (f7 == 7'h00) e.alu_op = op_from_func3(f3);
                else if (f7 == 7'h20 && f3 == 3'd0) e.alu_op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5) e.alu_op = SRA;
                else legal = 1'b0;
            end
            7'b0110111: begin
                e.write_enable = 1'b1;
                e.b_sel = IMM;
            end
            7'b0010111: begin
                e.write_enable = 1'b1;
                e.a_sel = PC;
                e.b_sel = IMM;
            end
            7'b0000011: begin
                e.write_enable = 1'b1;
                e.b_sel = IMM;
                e.wb = MEM;
                use1 = 1'b1;
            end
            7'b0100011: begin
                e.b_sel = IMM;
                e.store = 1'b1;
                use1 = 1'b1;
                use2 = 1'b1;
            end
            7'b1100011: begin
                e.a_sel = PC;
                e.b_sel = IMM;
                use1 = 1'b1;
                use2 = 1'b1;
                case (f3)
                    3'd0: e.jump = BEQ;
                    3'd1: e.jump = BNE;
                    3'd4: e.jump = BLT;
                    3'd5: e.jump = BGE;
                    3'd6: e.jump = BLTU;
                    3'd7: e.jump = BGEU;
                    default: e.jump = BNONE;
                endcase
            end
            7'b1101111: begin
                e.write_enable = 1'b1;
                e.a_sel = PC;
                e.b_sel = IMM;
                e.wb = PC_4;
                e.jump = JUMP;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            e = '{pc: pc, instr: instr, write_enable: 1'b0, a_sel: RS1, b_sel: RS2, alu_op: ADD,
                  wb: ALU, store: 1'b0, jump: BNONE, rs1: '0, rs2: '0, rd: '0};
            use1 = 1'b0;
            use2 = 1'b0;
        end
        e.rs1 = use1 ? instr[19:15] : 5'd0;
        e.rs2 = use2 ? instr[24:20] : 5'd0;
        e.rd = e.write_enable ? instr[11:7] : 5'd0;
        return e;
    endfunction

endpackage

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage_tb
    import riscv_decode_pkg::*;
    import decode_ref_pkg::*;
();

    localparam int WAIT_LIMIT = 500;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] pc_i;
    instr_t      instr_i;
    logic        out_valid_o;
    logic        out_ready_i;
    logic [31:0] pc_o;
    instr_t      instr_o;
    logic        write_enable_o;
    op_a_sel_e   rs1_or_pc_o;
    op_b_sel_e   rs2_or_imm_o;
    alu_op_e     alu_op_o;
    wb_origin_e  wb_origin_o;
    logic        store_to_mem_o;
    jump_kind_e  jump_kind_o;
    logic [4:0]  addr_rs1_o;
    logic [4:0]  addr_rs2_o;
    logic [4:0]  addr_rd_o;

    exp_t        pending[$];
    logic [31:0] stim_lfsr = 32'hfd39;
    logic [31:0] ready_lfsr = 32'hfd39;
    logic        ready_random = 1'b0;
    logic        after_reset = 1'b0;
    logic        accepted_last = 1'b0;
    logic        stalled_last = 1'b0;
    logic        timed_out = 1'b0;
    logic [91:0] held_bus;
    logic [91:0] out_bus;
    logic [31:0] next_pc = 32'h1000;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    assign out_bus = {pc_o, instr_o, write_enable_o, rs1_or_pc_o, rs2_or_imm_o, alu_op_o,
                      wb_origin_o, store_to_mem_o, jump_kind_o, addr_rs1_o, addr_rs2_o,
                      addr_rd_o};

    decode_stage dut0 (.*);

    always #5 clk_i = ~clk_i;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(logic cond, string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    // out_ready_i is mostly high under random mode
    always @(posedge clk_i) begin
        #1;
        ready_lfsr = lfsr_next(ready_lfsr);
        ready_lfsr = lfsr_next(ready_lfsr);
        out_ready_i = ready_random ? |ready_lfsr[1:0] : 1'b1;
    end

    always @(posedge clk_i) begin
        exp_t e;
        if (rst_i) begin
            pending.delete();
            after_reset = 1'b1;
            accepted_last = 1'b0;
            stalled_last = 1'b0;
        end else begin
            if (after_reset) begin
                check_true(!out_valid_o && in_ready_o, "stage not empty and ready after reset");
                after_reset = 1'b0;
            end
            if (accepted_last) begin
                check_true(out_valid_o, "accepted input did not appear after one edge");
            end
            if (stalled_last) begin
                check_true(out_valid_o && out_bus == held_bus, "outputs changed while stalled");
            end
            if (out_valid_o && !out_ready_i) begin
                check_true(!in_ready_o, "in_ready_o high while stalled");
            end
            if (out_valid_o && out_ready_i) begin
                check_true(pending.size() > 0, "output transfer without an accepted input");
                if (pending.size() > 0) begin
                    e = pending.pop_front();
                    check_field("pc_o", pc_o, e.pc);
                    check_field("instr_o", instr_o, e.instr);
                    check_field("write_enable_o", 32'(write_enable_o), 32'(e.write_enable));
                    check_field("rs1_or_pc_o", 32'(rs1_or_pc_o), 32'(e.a_sel));
                    check_field("rs2_or_imm_o", 32'(rs2_or_imm_o), 32'(e.b_sel));
                    check_field("alu_op_o", 32'(alu_op_o), 32'(e.alu_op));
                    check_field("wb_origin_o", 32'(wb_origin_o), 32'(e.wb));
                    check_field("store_to_mem_o", 32'(store_to_mem_o), 32'(e.store));
                    check_field("jump_kind_o", 32'(jump_kind_o), 32'(e.jump));
                    check_field("addr_rs1_o", 32'(addr_rs1_o), 32'(e.rs1));
                    check_field("addr_rs2_o", 32'(addr_rs2_o), 32'(e.rs2));
                    check_field("addr_rd_o", 32'(addr_rd_o), 32'(e.rd));
                end
            end
            if (in_valid_i && in_ready_o) begin
                pending.push_back(ref_decode(pc_i, instr_i));
            end
            accepted_last = in_valid_i && in_ready_o;
            stalled_last = out_valid_o && !out_ready_i;
            held_bus = out_bus;
        end
    end

    task automatic send(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        logic [31:0] regs;
        int          tries;
        take_bits(15, regs);
        in_valid_i = 1'b1;
        pc_i = next_pc;
        instr_i = {f7, regs[14:10], regs[9:5], f3, regs[4:0], op};
        next_pc = next_pc + 32'd4;
        tries = 0;
        @(negedge clk_i);
        while (!in_ready_o && !timed_out) begin
            tries++;
            if (tries > WAIT_LIMIT) begin
                report_timeout("in_ready_o");
            end else begin
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic drain(string name);
        int tries;
        tries = 0;
        while ((pending.size() > 0 || out_valid_o) && !timed_out) begin
            tries++;
            if (tries > WAIT_LIMIT) begin
                report_timeout("the output queue to drain");
            end else begin
                @(posedge clk_i);
                #1;
            end
        end
        $display("test %s done: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [6:0]  legal_ops [8];
        logic [6:0]  op;
        logic [6:0]  f7;
        legal_ops = '{7'b0010011, 7'b0110011, 7'b0110111, 7'b0010111,
                      7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111};
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        instr_i = '0;
        out_ready_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(posedge clk_i);
        #1;
        drain("reset");

        for (int f3 = 0; f3 < 8; f3++) begin
            foreach (legal_ops[k]) begin
                if (k < 2) begin
                    send(7'h00, 3'(f3), legal_ops[k]);
                    send(7'h20, 3'(f3), legal_ops[k]);
                    send(7'h01, 3'(f3), legal_ops[k]);
                end
            end
        end
        drain("alu_forms");

        send(7'h40, 3'd0, 7'b0110011);
        send(7'h20, 3'd1, 7'b0010011);
        send(7'h00, 3'd0, 7'b1100111);
        send(7'h00, 3'd0, 7'b0001111);
        send(7'h7f, 3'd7, 7'b1111111);
        send(7'h00, 3'd0, 7'b0000000);
        drain("illegal");

        for (int k = 2; k < 8; k++) begin
            if (k != 6) begin
                take_bits(10, r);
                send(r[6:0], r[9:7], legal_ops[k]);
                send(7'h00, 3'd0, legal_ops[k]);
            end
        end
        drain("lui_auipc_lw_sw_jal");

        for (int f3 = 0; f3 < 8; f3++) begin
            send(7'h00, 3'(f3), 7'b1100011);
        end
        drain("branches");

        ready_random = 1'b1;
        for (int n = 0; n < 400; n++) begin
            take_bits(16, r);
            op = r[3] ? r[10:4] : legal_ops[r[2:0]];
            f7 = (r[12:11] == 2'd0) ? 7'h00 : (r[12:11] == 2'd1) ? 7'h20 : {r[15:13], r[3:0]};
            take_bits(3, r);
            send(f7, r[2:0], op);
        end
        drain("random_backpressure");
        ready_random = 1'b0;

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== decode_stage.f ====
+incdir+include
logic/riscv_decode_pkg.sv
logic/decoded_if.sv
logic/alu_op_decoder.sv
logic/instr_classifier.sv
logic/decode_output_reg.sv
logic/decode_stage.sv
verification/decode_ref_pkg.sv
verification/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decode_stage.f \
    --top-module decode_stage_tb -o decode_sim --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1
